// ==== build.f ====
+incdir+source
+incdir+verification
source/spy_pkg.sv
source/spy_decode.sv
source/spy_regs.sv
source/spy_clock_ctl.sv
source/spy_read_mux.sv
source/spy_top.sv
verification/spy_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the spy port testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f build.f --top-module spy_tb -Mdir sim_build -o spy_sim \
   || { echo "Verilator build failed"; exit 1; }
./sim_build/spy_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log || { echo "FAIL: no pass line"; exit 1; }
echo "PASS"

// ==== verification/spy_tb_tasks.svh ====
// ##########################################################################
// Directed tests
// ##########################################################################

// Zero or random values on every processor input
task automatic drive_proc_values(input logic random);
   pc      = random ? rand_bits(16) : '0;
   ob_low  = random ? rand_bits(16) : '0;
   ob_high = random ? rand_bits(16) : '0;
   st_low  = random ? rand_bits(16) : '0;
   st_high = random ? rand_bits(16) : '0;
   a_low   = random ? rand_bits(16) : '0;
   a_high  = random ? rand_bits(16) : '0;
   m_low   = random ? rand_bits(16) : '0;
   m_high  = random ? rand_bits(16) : '0;
   flag1   = random ? rand_bits(16) : '0;
   disk    = random ? rand_bits(16) : '0;
   bd      = random ? rand_bits(16) : '0;
endtask

task automatic check_regs();
   spy_word_t w;
   int        addrs [9] = '{0, 1, 2, 3, 4, 16, 17, 18, 19};
   foreach (addrs[i]) begin
      read_word(spy_addr_t'(addrs[i]), w);
      check_word($sformatf("register at address %0d", addrs[i]), w, reg_expect(addrs[i]));
   end
   check_ir("dbir port", dbir, {shadow[2], shadow[1], shadow[0]});
   check_word("mode port", mode, shadow[5]);
endtask

task automatic hold_clk_en(input logic level, input int cycles);
   for (int i = 0; i < cycles; i++) begin
      check_bit("cpu_clk_en", cpu_clk_en, level);
      @(posedge clk);
      #1;
   end
endtask

task automatic test_reset();
   spy_word_t w;
   check_word("data_out after reset", data_out, '0);
   check_bit("cpu_clk_en after reset", cpu_clk_en, 1'b0);
   check_regs();
   read_word(5'd9, w);
   check_word("flag2 after reset", w, '0);
endtask

task automatic test_write_read();
   spy_word_t w;
   for (int i = 0; i < `SPY_LOAD_N; i++) begin
      w = rand_bits(16);
      // Clock controller stays idle here
      if (i == 3) begin
         w[`SPY_CLK_RUN_BIT]  = 1'b0;
         w[`SPY_CLK_STEP_BIT] = 1'b0;
      end
      shadow[i] = w;
      write_word(spy_addr_t'(i), w);
   end
   check_regs();
   read_word(5'd9, w);
   check_word("flag2 mode byte", w, {shadow[5][7:0], 8'h00});
endtask

// OB shows up at 6/7 and again at 20/21
task automatic test_proc_values();
   spy_word_t w;
   drive_proc_values(1'b1);
   for (int a = 5; a < 24; a++) begin
      if (a != 9 && (a < 16 || a > 19)) begin
         read_word(spy_addr_t'(a), w);
         check_word($sformatf("processor value at address %0d", a), w, proc_expect(a));
      end
   end
endtask

task automatic test_hold_unused();
   spy_word_t w;
   read_word(5'd0, w);
   eadr = 5'd22;
   idle_cycles(3);
   check_word("data_out held with dbread low", data_out, reg_expect(0));
   for (int a = 24; a < 32; a++) begin
      read_word(spy_addr_t'(a), w);
      check_word($sformatf("unused read address %0d", a), w, '0);
   end
   for (int a = 12; a < 32; a++) begin
      write_word(spy_addr_t'(a), rand_bits(16));
   end
   check_bit("cpu_clk_en after unused writes", cpu_clk_en, 1'b0);
   check_regs();
endtask

// Count enabled cycles, flag2 busy lags the enable by one cycle
task automatic step_and_count(input spy_step_t n);
   int count;
   count = 0;
   write_word(5'd3, {n, 6'b0, 1'b1, 1'b0});
   eadr   = 5'd9;
   dbread = 1'b1;
   while (cpu_clk_en === 1'b1 && count < WAIT_LIMIT) begin
      count++;
      @(posedge clk);
      #1;
      check_word("flag2 while stepping", data_out, {shadow[5][7:0], 8'h02});
   end
   dbread = 1'b0;
   if (count >= WAIT_LIMIT) begin
      timeout_stop("cpu_clk_en never dropped after a step write");
   end
   check_word($sformatf("enabled cycles for step count %0d", n),
              spy_word_t'(count), spy_word_t'(n));
   hold_clk_en(1'b0, 3);
endtask

task automatic test_clock_ctl();
   spy_word_t w;
   w         = rand_bits(16);
   shadow[5] = w;
   write_word(5'd5, w);
   step_and_count(8'd1);
   step_and_count(8'd7);
   step_and_count(spy_step_t'(rand_bits(8)) | 8'd1);
   step_and_count(8'd0);
   // Run and step together with count 5, run wins
   write_word(5'd3, 16'h0503);
   hold_clk_en(1'b1, 12);
   read_word(5'd9, w);
   check_word("flag2 while running", w, {shadow[5][7:0], 8'h01});
   write_word(5'd3, 16'h0000);
   hold_clk_en(1'b0, 4);
   read_word(5'd9, w);
   check_word("flag2 after stop", w, {shadow[5][7:0], 8'h00});
endtask

// ==== verification/spy_tb.sv ====
`timescale 1ns/1ps
`include "spy_consts.svh"

module spy_tb import spy_pkg::*; ();

   localparam int WAIT_LIMIT = 300;

   logic      clk;
   logic      rst_n;
   spy_addr_t eadr;
   logic      dbread;
   logic      dbwrite;
   spy_word_t data_in;
   spy_word_t pc;
   spy_word_t ob_low;
   spy_word_t ob_high;
   spy_word_t st_low;
   spy_word_t st_high;
   spy_word_t a_low;
   spy_word_t a_high;
   spy_word_t m_low;
   spy_word_t m_high;
   spy_word_t flag1;
   spy_word_t disk;
   spy_word_t bd;
   spy_word_t data_out;
   spy_ir_t   dbir;
   spy_word_t mode;
   logic      cpu_clk_en;

   // Expected loadable words, in load strobe order
   spy_word_t   shadow [`SPY_LOAD_N];
   logic [15:0] lfsr_q;
   int          error_count;

   spy_top u_dut (
      .clk(clk), .rst_n(rst_n), .eadr(eadr), .dbread(dbread), .dbwrite(dbwrite),
      .data_in(data_in), .pc(pc), .ob_low(ob_low), .ob_high(ob_high),
      .st_low(st_low), .st_high(st_high), .a_low(a_low), .a_high(a_high),
      .m_low(m_low), .m_high(m_high), .flag1(flag1), .disk(disk), .bd(bd),
      .data_out(data_out), .dbir(dbir), .mode(mode), .cpu_clk_en(cpu_clk_en)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step for each bit taken
   function automatic spy_word_t rand_bits(input int n);
      spy_word_t w;
      logic      fb;
      w = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
         lfsr_q = {lfsr_q[14:0], fb};
         w      = {w[14:0], fb};
      end
      return w;
   endfunction

   // ##########################################################################
   // Compare tasks
   // ##########################################################################

   task automatic stop_run();
      error_count++;
      $display("Simulation failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic timeout_stop(input string what);
      $display("Timeout at %0t: %s", $time, what);
      stop_run();
   endtask

   task automatic check_word(input string what, input spy_word_t got, input spy_word_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
         stop_run();
      end
   endtask

   task automatic check_ir(input string what, input spy_ir_t got, input spy_ir_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
         stop_run();
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
         stop_run();
      end
   endtask

   // ##########################################################################
   // Host bus, every task starts and ends 1 ns after a rising edge
   // ##########################################################################

   task automatic write_word(input spy_addr_t addr, input spy_word_t w);
      eadr    = addr;
      data_in = w;
      dbwrite = 1'b1;
      @(posedge clk);
      #1;
      dbwrite = 1'b0;
   endtask

   task automatic read_word(input spy_addr_t addr, output spy_word_t w);
      eadr   = addr;
      dbread = 1'b1;
      @(posedge clk);
      #1;
      dbread = 1'b0;
      w      = data_out;
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         @(posedge clk);
         #1;
      end
   endtask

   // Register read addresses 0 to 4 and 16 to 19
   function automatic spy_word_t reg_expect(input int addr);
      case (addr)
         0, 1, 2: return shadow[addr];
         3:       return {shadow[7][15:8], shadow[6][7:0]};
         4:       return shadow[4];
         default: return shadow[addr - 8];
      endcase
   endfunction

   function automatic spy_word_t proc_expect(input int addr);
      case (addr)
         5:       return pc;
         6, 20:   return ob_low;
         7, 21:   return ob_high;
         8:       return flag1;
         10:      return m_low;
         11:      return m_high;
         12:      return a_low;
         13:      return a_high;
         14:      return st_low;
         15:      return st_high;
         22:      return disk;
         23:      return bd;
         default: return '0;
      endcase
   endfunction

   `include "spy_tb_tasks.svh"

   initial begin
      error_count = 0;
      lfsr_q      = 16'(88686);
      rst_n       = 1'b0;
      eadr        = '0;
      dbread      = 1'b0;
      dbwrite     = 1'b0;
      data_in     = '0;
      drive_proc_values(1'b0);
      for (int i = 0; i < `SPY_LOAD_N; i++) begin
         shadow[i] = '0;
      end
      idle_cycles(2);
      rst_n = 1'b1;

      test_reset();
      test_write_read();
      test_proc_values();
      test_hold_unused();
      test_clock_ctl();

      if (error_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== source/spy_top.sv ====
`timescale 1ns/1ps

module spy_top import spy_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  spy_addr_t eadr,
   input  logic      dbread,
   input  logic      dbwrite,
   input  spy_word_t data_in,
   input  spy_word_t pc,
   input  spy_word_t ob_low,
   input  spy_word_t ob_high,
   input  spy_word_t st_low,
   input  spy_word_t st_high,
   input  spy_word_t a_low,
   input  spy_word_t a_high,
   input  spy_word_t m_low,
   input  spy_word_t m_high,
   input  spy_word_t flag1,
   input  spy_word_t disk,
   input  spy_word_t bd,
   output spy_word_t data_out,
   output spy_ir_t   dbir,
   output spy_word_t mode,
   output logic      cpu_clk_en
);

   // Position of the ldclk strobe
   localparam int LD_CLK = 3;

   spy_rsel_t read_sel;
   spy_load_t load_sel;
   spy_word_t opc;
   spy_word_t scratch;
   spy_word_t md_low;
   spy_word_t md_high;
   spy_word_t vma_low;
   spy_word_t vma_high;
   logic      run;
   logic      step_busy;

   spy_decode u_decode (
      .eadr     (eadr),
      .dbread   (dbread),
      .dbwrite  (dbwrite),
      .read_sel (read_sel),
      .load_sel (load_sel)
   );

   spy_regs u_regs (
      .clk      (clk),
      .rst_n    (rst_n),
      .load_sel (load_sel),
      .data_in  (data_in),
      .dbir     (dbir),
      .opc      (opc),
      .scratch  (scratch),
      .mode     (mode),
      .md_low   (md_low),
      .md_high  (md_high),
      .vma_low  (vma_low),
      .vma_high (vma_high)
   );

   spy_clock_ctl u_clock_ctl (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_clk   (load_sel[LD_CLK]),
      .data_in    (data_in),
      .cpu_clk_en (cpu_clk_en),
      .run        (run),
      .step_busy  (step_busy)
   );

   spy_read_mux u_read_mux (
      .clk       (clk),
      .rst_n     (rst_n),
      .dbread    (dbread),
      .read_sel  (read_sel),
      .dbir      (dbir),
      .opc       (opc),
      .scratch   (scratch),
      .mode      (mode),
      .md_low    (md_low),
      .md_high   (md_high),
      .vma_low   (vma_low),
      .vma_high  (vma_high),
      .run       (run),
      .step_busy (step_busy),
      .pc        (pc),
      .ob_low    (ob_low),
      .ob_high   (ob_high),
      .st_low    (st_low),
      .st_high   (st_high),
      .a_low     (a_low),
      .a_high    (a_high),
      .m_low     (m_low),
      .m_high    (m_high),
      .flag1     (flag1),
      .disk      (disk),
      .bd        (bd),
      .data_out  (data_out)
   );

endmodule

// ==== source/spy_read_mux.sv ====
`timescale 1ns/1ps
`include "spy_consts.svh"

module spy_read_mux import spy_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      dbread,
   input  spy_rsel_t read_sel,
   input  spy_ir_t   dbir,
   input  spy_word_t opc,
   input  spy_word_t scratch,
   input  spy_word_t mode,
   input  spy_word_t md_low,
   input  spy_word_t md_high,
   input  spy_word_t vma_low,
   input  spy_word_t vma_high,
   input  logic      run,
   input  logic      step_busy,
   input  spy_word_t pc,
   input  spy_word_t ob_low,
   input  spy_word_t ob_high,
   input  spy_word_t st_low,
   input  spy_word_t st_high,
   input  spy_word_t a_low,
   input  spy_word_t a_high,
   input  spy_word_t m_low,
   input  spy_word_t m_high,
   input  spy_word_t flag1,
   input  spy_word_t disk,
   input  spy_word_t bd,
   output spy_word_t data_out
);

   localparam int W = `SPY_DATA_W;

   spy_word_t flag2;
   spy_word_t rd_src [`SPY_RSEL_N];
   spy_word_t rd_word;

   // Mode byte on top, clock status in the two low bits
   assign flag2 = {mode[7:0], 6'b0, step_busy, run};

   // Sources indexed by read address
   assign rd_src[0]  = dbir[0 +: W];
   assign rd_src[1]  = dbir[W +: W];
   assign rd_src[2]  = dbir[2*W +: W];
   assign rd_src[3]  = scratch;
   assign rd_src[4]  = opc;
   assign rd_src[5]  = pc;
   assign rd_src[6]  = ob_low;
   assign rd_src[7]  = ob_high;
   assign rd_src[8]  = flag1;
   assign rd_src[9]  = flag2;
   assign rd_src[10] = m_low;
   assign rd_src[11] = m_high;
   assign rd_src[12] = a_low;
   assign rd_src[13] = a_high;
   assign rd_src[14] = st_low;
   assign rd_src[15] = st_high;
   assign rd_src[16] = md_low;
   assign rd_src[17] = md_high;
   assign rd_src[18] = vma_low;
   assign rd_src[19] = vma_high;
   assign rd_src[20] = ob_low;
   assign rd_src[21] = ob_high;
   assign rd_src[22] = disk;
   assign rd_src[23] = bd;

   // AND-OR mux, an unused address has no select and reads as zero
   always_comb begin
      rd_word = '0;
      for (int i = 0; i < `SPY_RSEL_N; i++) begin
         if (read_sel[i]) begin
            rd_word = rd_word | rd_src[i];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         data_out <= '0;
      end else if (dbread) begin
         data_out <= rd_word;
      end
   end

endmodule

// ==== source/spy_clock_ctl.sv ====
`timescale 1ns/1ps
`include "spy_consts.svh"

module spy_clock_ctl import spy_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      load_clk,
   input  spy_word_t data_in,
   output logic      cpu_clk_en,
   output logic      run,
   output logic      step_busy
);

   clk_state_t state;
   spy_step_t  step_cnt;

   // Fields of the control word
   logic      req_run;
   logic      req_step;
   spy_step_t req_cnt;

   assign req_run  = data_in[`SPY_CLK_RUN_BIT];
   assign req_step = data_in[`SPY_CLK_STEP_BIT];
   assign req_cnt  = data_in[`SPY_STEP_LSB +: `SPY_STEP_W];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= IDLE;
         step_cnt <= '0;
      end else if (load_clk) begin
         // A new control word restarts the controller
         // Run wins over step
         step_cnt <= req_cnt;
         if (req_run) begin
            state <= RUN;
         end else if (req_step && (req_cnt != '0)) begin
            state <= STEP;
         end else begin
            state <= IDLE;
         end
      end else begin
         case (state)
            STEP: begin
               // Last enabled cycle when the count reaches one
               if (step_cnt == spy_step_t'(1)) begin
                  state <= IDLE;
               end
               step_cnt <= step_cnt - spy_step_t'(1);
            end
            RUN:     state <= RUN;
            default: state <= IDLE;
         endcase
      end
   end

   assign run        = (state == RUN);
   assign step_busy  = (state == STEP);
   assign cpu_clk_en = run | step_busy;

endmodule

// ==== source/spy_regs.sv ====
`timescale 1ns/1ps
`include "spy_consts.svh"

module spy_regs import spy_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  spy_load_t load_sel,
   input  spy_word_t data_in,
   output spy_ir_t   dbir,
   output spy_word_t opc,
   output spy_word_t scratch,
   output spy_word_t mode,
   output spy_word_t md_low,
   output spy_word_t md_high,
   output spy_word_t vma_low,
   output spy_word_t vma_high
);

   // Strobe positions in load_sel
   localparam int LD_DBIR_L   = 0;
   localparam int LD_DBIR_M   = 1;
   localparam int LD_DBIR_H   = 2;
   localparam int LD_OPC      = 4;
   localparam int LD_MODE     = 5;
   localparam int LD_SCRATCH1 = 6;
   localparam int LD_SCRATCH2 = 7;
   localparam int LD_MD_L     = 8;
   localparam int LD_MD_H     = 9;
   localparam int LD_VMA_L    = 10;
   localparam int LD_VMA_H    = 11;

   localparam int W      = `SPY_DATA_W;
   localparam int BYTE_W = `SPY_DATA_W / 2;

   // ##########################################################################
   // Diagnostic IR, loaded one 16-bit piece at a time
   // ##########################################################################

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dbir <= '0;
      end else begin
         if (load_sel[LD_DBIR_L]) begin
            dbir[0 +: W] <= data_in;
         end
         if (load_sel[LD_DBIR_M]) begin
            dbir[W +: W] <= data_in;
         end
         if (load_sel[LD_DBIR_H]) begin
            dbir[2*W +: W] <= data_in;
         end
      end
   end

   // ##########################################################################
   // Old PC, mode and scratch
   // ##########################################################################

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         opc     <= '0;
         mode    <= '0;
         scratch <= '0;
      end else begin
         if (load_sel[LD_OPC]) begin
            opc <= data_in;
         end
         if (load_sel[LD_MODE]) begin
            mode <= data_in;
         end
         // Each scratch half takes its own byte lane of the host word
         if (load_sel[LD_SCRATCH1]) begin
            scratch[0 +: BYTE_W] <= data_in[0 +: BYTE_W];
         end
         if (load_sel[LD_SCRATCH2]) begin
            scratch[BYTE_W +: BYTE_W] <= data_in[BYTE_W +: BYTE_W];
         end
      end
   end

   // ##########################################################################
   // Memory interface registers
   // ##########################################################################

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         md_low   <= '0;
         md_high  <= '0;
         vma_low  <= '0;
         vma_high <= '0;
      end else begin
         if (load_sel[LD_MD_L]) begin
            md_low <= data_in;
         end
         if (load_sel[LD_MD_H]) begin
            md_high <= data_in;
         end
         if (load_sel[LD_VMA_L]) begin
            vma_low <= data_in;
         end
         if (load_sel[LD_VMA_H]) begin
            vma_high <= data_in;
         end
      end
   end

endmodule

// ==== source/spy_decode.sv ====
`timescale 1ns/1ps
`include "spy_consts.svh"

module spy_decode import spy_pkg::*; (
   input  spy_addr_t eadr,
   input  logic      dbread,
   input  logic      dbwrite,
   output spy_rsel_t read_sel,
   output spy_load_t load_sel
);

   localparam int TOP = `SPY_ADDR_W - 1;

   // Bank qualifiers
   logic rd_lo_bank;
   logic rd_hi_bank;
   logic wr_lo_bank;
   logic wr_mem_bank;

   // ##########################################################################
   // Read selects
   // ##########################################################################

   // Addresses 0 to 15 when the top bit is clear
   assign rd_lo_bank = dbread & ~eadr[TOP];

   // Addresses 16 to 23, the rest of the upper half is unused
   assign rd_hi_bank = dbread & eadr[TOP] & ~eadr[TOP-1];

   always_comb begin
      read_sel = '0;
      if (rd_lo_bank) begin
         read_sel[15:0] = 16'h0001 << eadr[3:0];
      end
      if (rd_hi_bank) begin
         read_sel[23:16] = 8'h01 << eadr[2:0];
      end
   end

   // ##########################################################################
   // Load strobes
   // ##########################################################################

   // Addresses 0 to 7, dbir low through scratch2
   assign wr_lo_bank = dbwrite & (eadr[TOP:3] == 2'b00);

   // Addresses 8 to 11, md and vma halves
   assign wr_mem_bank = dbwrite & (eadr[TOP:2] == 3'b010);

   always_comb begin
      load_sel = '0;
      if (wr_lo_bank) begin
         load_sel[7:0] = 8'h01 << eadr[2:0];
      end
      if (wr_mem_bank) begin
         load_sel[11:8] = 4'h1 << eadr[1:0];
      end
   end

endmodule

// ==== source/spy_pkg.sv ====
`include "spy_consts.svh"

package spy_pkg;

   // Host side words
   typedef logic [`SPY_DATA_W-1:0] spy_word_t;
   typedef logic [`SPY_ADDR_W-1:0] spy_addr_t;

   // One-hot read select, bit n selects read address n
   typedef logic [`SPY_RSEL_N-1:0] spy_rsel_t;

   // One-hot load strobe
   //   0 dbir low, 1 dbir mid, 2 dbir high, 3 clk
   //   4 opc, 5 mode, 6 scratch1, 7 scratch2
   //   8 md low, 9 md high, 10 vma low, 11 vma high
   typedef logic [`SPY_LOAD_N-1:0] spy_load_t;

   // Diagnostic instruction register
   typedef logic [`SPY_IR_W-1:0] spy_ir_t;

   // Single step cycle count
   typedef logic [`SPY_STEP_W-1:0] spy_step_t;

   // Clock control FSM
   typedef enum logic [1:0] {
      IDLE = 2'd0,
      RUN  = 2'd1,
      STEP = 2'd2
   } clk_state_t;

endpackage

// ==== source/spy_consts.svh ====
`ifndef SPY_CONSTS_SVH
`define SPY_CONSTS_SVH

// ##########################################################################
// Spy port widths
// ##########################################################################

`define SPY_DATA_W 16
`define SPY_ADDR_W 5
`define SPY_IR_W 48

// Read selects cover addresses 0 to 23, loads cover 0 to 11
`define SPY_RSEL_N 24
`define SPY_LOAD_N 12

// ##########################################################################
// Fields of the word written at the ldclk address
// ##########################################################################

`define SPY_CLK_RUN_BIT 0
`define SPY_CLK_STEP_BIT 1
`define SPY_STEP_LSB 8
`define SPY_STEP_W 8

`endif
